// File: hdl/periph_pkg.sv
// APB request and response structs, address width, register offset and serializer state enums
package periph_pkg;

	localparam int APB_ADDR_W = 16;

	// ------------------------------------------------------------------
	// APB signals, requester to completer and back

	typedef struct packed {
		logic                  sel;
		logic                  enable;
		logic                  write;
		logic [APB_ADDR_W-1:0] addr;
		logic [31:0]           wdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        ready;
		logic        slverr;
	} apb_rsp_t;

	// ------------------------------------------------------------------
	// Register offsets within each completer

	// CTRL bit 0 enables counting
	typedef enum logic [15:0] {
		CTRL      = 16'h0000,
		MTIME     = 16'h0008,
		MTIMEH    = 16'h000c,
		MTIMECMP  = 16'h0010,
		MTIMECMPH = 16'h0014
	} timer_reg_e;

	// CSR bit 0 enables the UART, bit 1 the TX-idle interrupt
	typedef enum logic [15:0] {
		CSR    = 16'h0000,
		DIV    = 16'h0004,
		TXDATA = 16'h0008,
		STAT   = 16'h000c
	} uart_reg_e;

	// Transmitter FSM
	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} ser_state_e;

endpackage

// File: hdl/apb_splitter.sv
// APB address decoder routing one requester to N completers and merging their responses
module apb_splitter import periph_pkg::*; #(
	parameter int                              N_SLAVES  = 2,
	parameter logic [N_SLAVES*APB_ADDR_W-1:0]  ADDR_MAP  = '0,
	parameter logic [N_SLAVES*APB_ADDR_W-1:0]  ADDR_MASK = '0
) (
	input  apb_req_t                 req,
	output apb_rsp_t                 rsp,

	output apb_req_t [N_SLAVES-1:0]  slv_req,
	input  apb_rsp_t [N_SLAVES-1:0]  slv_rsp
);

logic [N_SLAVES-1:0] sel_oh;
logic                found;

// ----------------------------------------------------------------------
// Address decode

// First matching entry wins if the map ever overlaps
always_comb begin
	sel_oh = '0;
	found = 1'b0;
	for (int i = 0; i < N_SLAVES; i++) begin
		if (!found && ((req.addr & ADDR_MASK[i*APB_ADDR_W +: APB_ADDR_W]) ==
				ADDR_MAP[i*APB_ADDR_W +: APB_ADDR_W])) begin
			sel_oh[i] = 1'b1;
			found = 1'b1;
		end
	end
end

// Everything but sel is broadcast
always_comb begin
	for (int i = 0; i < N_SLAVES; i++) begin
		slv_req[i] = req;
		slv_req[i].sel = req.sel && sel_oh[i];
	end
end

// ----------------------------------------------------------------------
// Response merge

always_comb begin
	rsp = '0;
	if (found) begin
		for (int i = 0; i < N_SLAVES; i++) begin
			if (sel_oh[i]) begin
				rsp = slv_rsp[i];
			end
		end
	end else begin
		// Hole in the map, error out in the access phase
		rsp.ready = req.sel && req.enable;
		rsp.slverr = req.sel && req.enable;
	end
end

endmodule

// File: hdl/mtime_timer.sv
// RISC-V machine timer with APB registers, tick-gated 64-bit counter and compare interrupt
module mtime_timer import periph_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,

	input  apb_req_t req,
	output apb_rsp_t rsp,

	input  logic     tick,
	input  logic     dbg_halt,
	output logic     timer_irq
);

logic                  ctrl_en;
logic [63:0]           mtime;
logic [63:0]           mtimecmp;

logic [APB_ADDR_W-1:0] offset;
logic                  access;
logic                  wr_en;
logic                  reg_hit;
logic [31:0]           rd_data;

// Register block is 256 bytes, upper bits alias
assign offset = {{(APB_ADDR_W-8){1'b0}}, req.addr[7:0]};
assign access = req.sel && req.enable;
assign wr_en = access && req.write && reg_hit;

// ----------------------------------------------------------------------
// APB decode and read data

always_comb begin
	rd_data = '0;
	reg_hit = 1'b1;
	case (offset)
		CTRL:      rd_data = {31'h0, ctrl_en};
		MTIME:     rd_data = mtime[31:0];
		MTIMEH:    rd_data = mtime[63:32];
		MTIMECMP:  rd_data = mtimecmp[31:0];
		MTIMECMPH: rd_data = mtimecmp[63:32];
		default:   reg_hit = 1'b0;
	endcase
	// Zero wait states
	rsp = '0;
	rsp.ready = access;
	rsp.slverr = access && !reg_hit;
	rsp.rdata = rd_data;
end

// ----------------------------------------------------------------------
// Counter, registers and interrupt

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		ctrl_en <= 1'b0;
		mtime <= '0;
		mtimecmp <= '1;
		timer_irq <= 1'b0;
	end else begin
		if (ctrl_en && tick && !dbg_halt) begin
			mtime <= mtime + 64'd1;
		end
		// A software write to a half overrides the count for that half
		if (wr_en) begin
			case (offset)
				CTRL:      ctrl_en <= req.wdata[0];
				MTIME:     mtime[31:0] <= req.wdata;
				MTIMEH:    mtime[63:32] <= req.wdata;
				MTIMECMP:  mtimecmp[31:0] <= req.wdata;
				MTIMECMPH: mtimecmp[63:32] <= req.wdata;
				default:   ;
			endcase
		end
		timer_irq <= mtime >= mtimecmp;
	end
end

endmodule

// File: hdl/uart_regs.sv
// UART register block with CSR, divisor, TX data and status, TX-idle interrupt and busy stall
module uart_regs import periph_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,

	input  apb_req_t    req,
	output apb_rsp_t    rsp,

	input  logic        busy,
	output logic        start,
	output logic [7:0]  tx_byte,
	output logic [15:0] div,
	output logic        uart_irq
);

logic                  csr_en;
logic                  csr_irq_en;

logic [APB_ADDR_W-1:0] offset;
logic                  access;
logic                  tx_write;
logic                  reg_hit;
logic [31:0]           rd_data;

assign offset = {{(APB_ADDR_W-8){1'b0}}, req.addr[7:0]};
assign access = req.sel && req.enable;
assign tx_write = access && req.write && (offset == TXDATA);

// Byte goes straight to the serializer on the completing edge
assign start = tx_write && !busy && csr_en;
assign tx_byte = req.wdata[7:0];

assign uart_irq = csr_irq_en && !busy;

// ----------------------------------------------------------------------
// APB decode

always_comb begin
	rd_data = '0;
	reg_hit = 1'b1;
	case (offset)
		CSR:     rd_data = {30'h0, csr_irq_en, csr_en};
		DIV:     rd_data = {16'h0, div};
		TXDATA:  reg_hit = req.write;  // write only
		STAT:    rd_data = {31'h0, busy};
		default: reg_hit = 1'b0;
	endcase
	rsp = '0;
	// Hold off a TX write until the frame in flight is out
	rsp.ready = access && !(tx_write && busy);
	rsp.slverr = access && !reg_hit;
	rsp.rdata = rd_data;
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		csr_en <= 1'b0;
		csr_irq_en <= 1'b0;
		div <= '0;
	end else if (access && req.write) begin
		if (offset == CSR) begin
			csr_en <= req.wdata[0];
			csr_irq_en <= req.wdata[1];
		end
		if (offset == DIV) begin
			div <= req.wdata[15:0];
		end
	end
end

endmodule

// File: hdl/uart_serializer.sv
// UART transmit serializer with start bit, eight data bits LSB first and stop bit
module uart_serializer import periph_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,

	input  logic        start,
	input  logic [7:0]  tx_byte,
	input  logic [15:0] div,

	output logic        busy,
	output logic        tx
);

ser_state_e  state;
logic [15:0] bit_cnt;
logic [2:0]  bit_idx;
logic [7:0]  shift;
logic        bit_done;

assign busy = state != IDLE;
// Each bit runs div+1 cycles
assign bit_done = busy && (bit_cnt == 16'd0);

// ----------------------------------------------------------------------
// Bit timing and FSM

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		state <= IDLE;
		bit_cnt <= '0;
		bit_idx <= '0;
		tx <= 1'b1;
	end else if (state == IDLE) begin
		if (start) begin
			state <= START;
			bit_cnt <= div;
			tx <= 1'b0;
		end
	end else if (!bit_done) begin
		bit_cnt <= bit_cnt - 16'd1;
	end else begin
		bit_cnt <= div;
		case (state)
			START: begin
				state <= DATA;
				bit_idx <= '0;
				tx <= shift[0];
			end
			DATA: begin
				if (bit_idx == 3'd7) begin
					state <= STOP;
					tx <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 3'd1;
					tx <= shift[0];
				end
			end
			default: state <= IDLE;
		endcase
	end
end

// Next bit to send always sits in shift[0]
always_ff @(posedge clk) begin
	if (state == IDLE && start) begin
		shift <= tx_byte;
	end else if (bit_done && state != STOP) begin
		shift <= {1'b0, shift[7:1]};
	end
end

endmodule

// File: hdl/periph_top.sv
// Peripheral subsystem top with APB splitter, machine timer and transmit UART
module periph_top import periph_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,

	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp,

	input  logic     tick,
	input  logic     dbg_halt,
	output logic     timer_irq,
	output logic     uart_irq,
	output logic     uart_tx
);

// ----------------------------------------------------------------------
// Address map
//   slot 0  timer  0x0000
//   slot 1  UART   0x4000

localparam int                          N_SLAVES  = 2;
localparam logic [N_SLAVES*APB_ADDR_W-1:0] ADDR_MAP  = {16'h4000, 16'h0000};
localparam logic [N_SLAVES*APB_ADDR_W-1:0] ADDR_MASK = {16'hc000, 16'hc000};

apb_req_t [N_SLAVES-1:0] slv_req;
apb_rsp_t [N_SLAVES-1:0] slv_rsp;

logic        uart_busy;
logic        uart_start;
logic [7:0]  uart_byte;
logic [15:0] uart_div;

apb_splitter #(
	.N_SLAVES  (N_SLAVES),
	.ADDR_MAP  (ADDR_MAP),
	.ADDR_MASK (ADDR_MASK)
) splitter_u (
	.req     (apb_req),
	.rsp     (apb_rsp),
	.slv_req (slv_req),
	.slv_rsp (slv_rsp)
);

mtime_timer timer_u (
	.clk       (clk),
	.arst_n    (arst_n),
	.req       (slv_req[0]),
	.rsp       (slv_rsp[0]),
	.tick      (tick),
	.dbg_halt  (dbg_halt),
	.timer_irq (timer_irq)
);

// ----------------------------------------------------------------------
// UART, registers beside the serializer they drive

uart_regs uart_regs_u (
	.clk      (clk),
	.arst_n   (arst_n),
	.req      (slv_req[1]),
	.rsp      (slv_rsp[1]),
	.busy     (uart_busy),
	.start    (uart_start),
	.tx_byte  (uart_byte),
	.div      (uart_div),
	.uart_irq (uart_irq)
);

uart_serializer uart_ser_u (
	.clk     (clk),
	.arst_n  (arst_n),
	.start   (uart_start),
	.tx_byte (uart_byte),
	.div     (uart_div),
	.busy    (uart_busy),
	.tx      (uart_tx)
);

endmodule

// File: verification/periph_tests.svh
// Directed tests for reset values, timer, UART frames, TX back-pressure and error responses
logic [15:0] div_exp;

function automatic int random_div();
	return 1 + int'(next_random() % 32'd7);
endfunction

task automatic program_uart(input int div, input logic [31:0] csr);
	logic err;
	apb_write(UART_BASE + DIV, 32'(div), err);
	apb_write(UART_BASE + CSR, csr, err);
	div_exp = 16'(div);
endtask

task automatic test_reset_values();
	int err0;
	err0 = errors;
	check_bit("timer_irq", timer_irq, 1'b0);
	check_bit("uart_irq", uart_irq, 1'b0);
	check_bit("uart_tx", uart_tx, 1'b1);
	read_and_check("CTRL", TIMER_BASE + CTRL, 32'h0);
	read_and_check("MTIMECMP", TIMER_BASE + MTIMECMP, 32'hffff_ffff);
	read_and_check("MTIMECMPH", TIMER_BASE + MTIMECMPH, 32'hffff_ffff);
	read_and_check("CSR", UART_BASE + CSR, 32'h0);
	read_and_check("DIV", UART_BASE + DIV, 32'h0);
	read_and_check("STAT", UART_BASE + STAT, 32'h0);
	finish_test("reset_values", err0);
endtask

task automatic test_timer_count();
	int          err0;
	int          n;
	int          counted;
	logic [63:0] start;
	logic [63:0] now;
	logic        err;
	err0 = errors;
	start = {next_random(), next_random()};
	n = 20 + int'(next_random() % 32'd40);
	counted = 0;
	apb_write(TIMER_BASE + MTIME, start[31:0], err);
	apb_write(TIMER_BASE + MTIMEH, start[63:32], err);
	apb_write(TIMER_BASE + CTRL, 32'h1, err);
	// Halted cycles do not count
	for (int i = 0; i < n; i++) begin
		@(negedge clk);
		tick = 1'b1;
		dbg_halt = (next_random() % 32'd4) == 32'd0;
		if (!dbg_halt) begin
			counted++;
		end
	end
	@(negedge clk);
	tick = 1'b0;
	dbg_halt = 1'b0;
	apb_write(TIMER_BASE + CTRL, 32'h0, err);
	now = start + 64'(counted);
	read_and_check("MTIME", TIMER_BASE + MTIME, now[31:0]);
	read_and_check("MTIMEH", TIMER_BASE + MTIMEH, now[63:32]);
	finish_test("timer_count", err0);
endtask

task automatic test_timer_irq();
	int          err0;
	int          k;
	logic [31:0] lo;
	logic [31:0] hi;
	logic [63:0] cmp;
	logic        err;
	err0 = errors;
	lo = next_random();
	hi = next_random() & 32'h7fff_ffff;
	k = 3 + int'(next_random() % 32'd16);
	cmp = {hi, lo} + 64'(k);
	apb_write(TIMER_BASE + MTIME, lo, err);
	apb_write(TIMER_BASE + MTIMEH, hi, err);
	apb_write(TIMER_BASE + MTIMECMP, cmp[31:0], err);
	apb_write(TIMER_BASE + MTIMECMPH, cmp[63:32], err);
	@(negedge clk);
	check_bit("timer_irq before enable", timer_irq, 1'b0);
	tick = 1'b1;
	apb_write(TIMER_BASE + CTRL, 32'h1, err);
	for (int i = 0; i < k + 8 && !timer_irq; i++) begin
		@(negedge clk);
	end
	check_bit("timer_irq", timer_irq, 1'b1);
	tick = 1'b0;
	apb_write(TIMER_BASE + CTRL, 32'h0, err);
	apb_read(TIMER_BASE + MTIME, lo, err);
	apb_read(TIMER_BASE + MTIMEH, hi, err);
	check_bit("mtime at or past mtimecmp", {hi, lo} >= cmp, 1'b1);
	apb_write(TIMER_BASE + MTIMECMPH, 32'hffff_ffff, err);
	@(negedge clk);
	check_bit("timer_irq after clear", timer_irq, 1'b0);
	finish_test("timer_irq", err0);
endtask

task automatic test_uart_frame();
	int          err0;
	int          div;
	logic [31:0] rd;
	logic [7:0]  data;
	logic [7:0]  got;
	logic        start_bit;
	logic        stop_bit;
	logic        err;
	err0 = errors;
	div = random_div();
	rd = next_random();
	data = rd[7:0];
	program_uart(div, 32'h3);
	fork
		receive_byte(div, got, start_bit, stop_bit);
		begin
			apb_write(UART_BASE + TXDATA, {24'h0, data}, err);
			apb_read(UART_BASE + STAT, rd, err);
			check_word("STAT during frame", rd, 32'h1);
			check_bit("uart_irq during frame", uart_irq, 1'b0);
		end
	join
	check_bit("start bit", start_bit, 1'b0);
	check_word("received byte", {24'h0, got}, {24'h0, data});
	check_bit("stop bit", stop_bit, 1'b1);
	for (int i = 0; i < 4 * (div + 1) && !uart_irq; i++) begin
		@(negedge clk);
	end
	check_bit("uart_irq after frame", uart_irq, 1'b1);
	finish_test("uart_frame", err0);
endtask

task automatic test_back_pressure();
	int          err0;
	int          div;
	logic [31:0] bytes;
	logic [7:0]  got0;
	logic [7:0]  got1;
	logic        s0;
	logic        s1;
	logic        p0;
	logic        p1;
	logic        tx_low;
	logic        err;
	err0 = errors;
	div = random_div();
	bytes = next_random();
	program_uart(div, 32'h1);
	fork
		begin
			receive_byte(div, got0, s0, p0);
			receive_byte(div, got1, s1, p1);
		end
		begin
			apb_write(UART_BASE + TXDATA, {24'h0, bytes[7:0]}, err);
			apb_write(UART_BASE + TXDATA, {24'h0, bytes[15:8]}, err);
			// Second write stalls from its first access cycle until the first frame ends
			check_word("TXDATA wait cycles", 32'(wait_cycles), 32'(10 * (div + 1) - 2));
		end
	join
	check_word("first byte", {24'h0, got0}, {24'h0, bytes[7:0]});
	check_word("second byte", {24'h0, got1}, {24'h0, bytes[15:8]});
	check_word("start and stop bits", {28'h0, s0, s1, p0, p1}, 32'h3);
	// Disabled UART drops the byte
	program_uart(div, 32'h0);
	apb_write(UART_BASE + TXDATA, {24'h0, bytes[23:16]}, err);
	tx_low = 1'b0;
	for (int i = 0; i < 10 * (div + 1) + 8; i++) begin
		@(negedge clk);
		if (!uart_tx) begin
			tx_low = 1'b1;
		end
	end
	check_bit("uart_tx low while disabled", tx_low, 1'b0);
	finish_test("back_pressure", err0);
endtask

task automatic test_errors();
	int          err0;
	apb_rsp_t    bad;
	logic [31:0] rd;
	logic        err;
	err0 = errors;
	bad = '{rdata: 32'h0, ready: 1'b1, slverr: 1'b1};
	apb_read(16'h8000, rd, err);
	check_rsp("read of 0x8000", last_rsp, bad);
	// Low bits set so a stray write would show up in CTRL or CSR
	apb_write(16'h8000, next_random() | 32'h3, err);
	check_rsp("write of 0x8000", last_rsp, bad);
	apb_read(TIMER_BASE + 16'h0004, rd, err);
	check_rsp("read of timer 0x04", last_rsp, bad);
	apb_write(TIMER_BASE + 16'h0004, next_random(), err);
	check_rsp("write of timer 0x04", last_rsp, bad);
	apb_read(UART_BASE + TXDATA, rd, err);
	check_rsp("read of TXDATA", last_rsp, bad);
	read_and_check("CTRL after errors", TIMER_BASE + CTRL, 32'h0);
	read_and_check("CSR after errors", UART_BASE + CSR, 32'h0);
	read_and_check("DIV after errors", UART_BASE + DIV, {16'h0, div_exp});
	finish_test("errors", err0);
endtask

// File: verification/periph_tb.sv
// Testbench top with clock, reset, watchdog, random source, APB driver, checkers and UART monitor
module periph_tb import periph_pkg::*; ();

localparam int CLK_PERIOD = 4;
localparam int RESET_CYCLES = 8;
localparam logic [APB_ADDR_W-1:0] TIMER_BASE = 16'h0000;
localparam logic [APB_ADDR_W-1:0] UART_BASE = 16'h4000;
// Reset plus the cycle budget of each directed test, in test order
localparam int WATCHDOG_CYCLES = RESET_CYCLES + 100 + 150 + 150 + 200 + 400 + 100;

logic        clk;
logic        arst_n;
apb_req_t    apb_req;
apb_rsp_t    apb_rsp;
logic        tick;
logic        dbg_halt;
logic        timer_irq;
logic        uart_irq;
logic        uart_tx;

logic [31:0] rng_state = 32'h737b;
apb_rsp_t    last_rsp;
int          wait_cycles = 0;
int          checks = 0;
int          errors = 0;
int          tests_run = 0;
int          tests_bad = 0;

periph_top UUT (
	.clk       (clk),
	.arst_n    (arst_n),
	.apb_req   (apb_req),
	.apb_rsp   (apb_rsp),
	.tick      (tick),
	.dbg_halt  (dbg_halt),
	.timer_irq (timer_irq),
	.uart_irq  (uart_irq),
	.uart_tx   (uart_tx)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

initial begin
	repeat (WATCHDOG_CYCLES) @(posedge clk);
	$display("Watchdog expired before the tests finished");
	$display("Test failed");
	$finish;
end

function automatic logic [31:0] next_random();
	rng_state ^= rng_state << 13;
	rng_state ^= rng_state >> 17;
	rng_state ^= rng_state << 5;
	return rng_state;
endfunction

// ----------------------------------------------------------------------
// Compare tasks

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Fail %s: got %h, expected %h", name, got, exp);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Fail %s: got %h, expected %h", name, got, exp);
	end
endtask

task automatic check_rsp(input string name, input apb_rsp_t got, input apb_rsp_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Fail %s: got rdata %h ready %h slverr %h, expected rdata %h ready %h slverr %h",
			name, got.rdata, got.ready, got.slverr, exp.rdata, exp.ready, exp.slverr);
	end
endtask

// ----------------------------------------------------------------------
// APB requester

// Response is sampled a quarter period after the falling edge
task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
		input logic [31:0] wdata);
	@(negedge clk);
	apb_req.sel = 1'b1;
	apb_req.enable = 1'b0;
	apb_req.write = wr;
	apb_req.addr = addr;
	apb_req.wdata = wdata;
	@(negedge clk);
	apb_req.enable = 1'b1;
	wait_cycles = 0;
	#(CLK_PERIOD / 4);
	while (!apb_rsp.ready) begin
		@(negedge clk);
		#(CLK_PERIOD / 4);
		wait_cycles++;
	end
	last_rsp = apb_rsp;
	@(negedge clk);
	apb_req = '0;
endtask

task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] wdata,
		output logic err);
	apb_xfer(1'b1, addr, wdata);
	err = last_rsp.slverr;
endtask

task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic err);
	apb_xfer(1'b0, addr, 32'h0);
	data = last_rsp.rdata;
	err = last_rsp.slverr;
endtask

task automatic read_and_check(input string name, input logic [APB_ADDR_W-1:0] addr,
		input logic [31:0] exp);
	logic [31:0] data;
	logic        err;
	apb_read(addr, data, err);
	check_word(name, data, exp);
	check_bit({name, " slverr"}, err, 1'b0);
endtask

// Samples uart_tx in the middle of each bit of one frame
task automatic receive_byte(input int div, output logic [7:0] data, output logic start_bit,
		output logic stop_bit);
	int bit_time;
	bit_time = CLK_PERIOD * (div + 1);
	@(negedge uart_tx);
	#(bit_time / 2);
	start_bit = uart_tx;
	for (int i = 0; i < 8; i++) begin
		#(bit_time);
		data[i] = uart_tx;
	end
	#(bit_time);
	stop_bit = uart_tx;
endtask

task automatic finish_test(input string name, input int err0);
	tests_run++;
	if (errors == err0) begin
		$display("%s: ok", name);
	end else begin
		tests_bad++;
		$display("%s: %0d errors", name, errors - err0);
	end
endtask

`include "periph_tests.svh"

initial begin
	arst_n = 1'b0;
	apb_req = '0;
	tick = 1'b0;
	dbg_halt = 1'b0;
	repeat (RESET_CYCLES) @(negedge clk);
	arst_n = 1'b1;
	test_reset_values();
	test_timer_count();
	test_timer_irq();
	test_uart_frame();
	test_back_pressure();
	test_errors();
	$display("%0d tests, %0d with errors, %0d checks, %0d errors",
		tests_run, tests_bad, checks, errors);
	if (errors == 0) begin
		$display("Test passed");
	end else begin
		$display("Test failed");
	end
	$finish;
end

endmodule

// File: periph.f
+incdir+verification
hdl/periph_pkg.sv
hdl/apb_splitter.sv
hdl/mtime_timer.sv
hdl/uart_regs.sv
hdl/uart_serializer.sv
hdl/periph_top.sv
verification/periph_tb.sv

// File: Makefile
TOP = periph_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f periph.f --top-module periph_top
	verilator --lint-only --timing -f periph.f --top-module $(TOP)

sim:
	verilator --binary --timing -f periph.f --top-module $(TOP) -Mdir obj_dir -o periph_sim
	./obj_dir/periph_sim | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
